// File: verilog/nco_params.svh
/* Widths shared by the NCO RTL and the bench. The table holds 2^NCO_INDEX_W + 1 entries and
   the angle (2 + NCO_INDEX_W + NCO_FRAC_W bits) must not be wider than NCO_PHASE_W */
`ifndef NCO_PARAMS_SVH
`define NCO_PARAMS_SVH

// Width of the phase accumulator, the frequency word and the phase offset
`define NCO_PHASE_W 24

// Index bits into the quarter-wave table
// The table spans 0 to pi/2 inclusive, so it has one entry more than 2^NCO_INDEX_W
`define NCO_INDEX_W 8

// Fraction bits used to interpolate between neighbouring table entries
`define NCO_FRAC_W 8

// Signed output sample width
// The table is scaled to the largest positive value of this width
`define NCO_SAMPLE_W 16

`endif

// File: verilog/phase_pkg.sv
/* Phase-side types. The angle struct is packed MSB first, so it can be cast straight from
   the top bits of a phase word */
`default_nettype none

`include "nco_params.svh"

package phase_pkg;

    // Unsigned phase word, wraps modulo 2^NCO_PHASE_W
    typedef logic [`NCO_PHASE_W-1:0] phase_t;

    // Decoded angle taken from the top of the phase word
    // Sector selects the quadrant, index addresses the table within it
    // and frac weights the step towards the next entry
    typedef struct packed {
        logic [1:0]              sector;
        logic [`NCO_INDEX_W-1:0] index;
        logic [`NCO_FRAC_W-1:0]  frac;
    } angle_fields_t;

endpackage

`default_nettype wire

// File: verilog/sample_pkg.sv
/* Amplitude-side types. Samples are two's complement and the table never uses the most
   negative code */
`default_nettype none

`include "nco_params.svh"

package sample_pkg;

    // One signed cosine sample
    typedef logic signed [`NCO_SAMPLE_W-1:0] sample_t;

    // Current table sample and the one that follows it in angle
    // Both already carry the sign of the quadrant they belong to
    typedef struct packed {
        sample_t cur;
        sample_t next;
    } sample_pair_t;

endpackage

`default_nettype wire

// File: verilog/nco_links.sv
/* Stage-to-stage links of the NCO pipeline. Valid is a one-cycle qualifier with no
   handshake, so a sink must take the payload on the cycle valid is high */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

// Decoded angle from the phase decoder to the cosine table
interface angle_if;

    logic                    valid;
    logic [1:0]              sector;
    logic [`NCO_INDEX_W-1:0] index;
    logic [`NCO_FRAC_W-1:0]  frac;

    // The decoder drives every field
    modport source (
        output valid, sector, index, frac
    );

    // The table only reads
    modport sink (
        input valid, sector, index, frac
    );

endinterface

// Signed sample pair from the cosine table to the interpolator
interface pair_if;

    logic                   valid;
    sample_pkg::sample_t    cur;
    sample_pkg::sample_t    next;
    logic [`NCO_FRAC_W-1:0] frac;

    // Frac travels with the pair so both reach the interpolator together
    modport source (
        output valid, cur, next, frac
    );

    modport sink (
        input valid, cur, next, frac
    );

endinterface

`default_nettype wire

// File: verilog/phase_decoder.sv
/* Phase accumulator and angle split. Low phase bits below the fraction are dropped, and
   the angle register only updates on cycles with enable high */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

module phase_decoder (
    input  logic              clk,
    input  logic              rst,
    input  logic              enable,
    input  phase_pkg::phase_t freq_word,
    input  phase_pkg::phase_t phase_offset,
    angle_if.source           angle
);

    // Number of phase bits that make up the decoded angle
    localparam int ANGLE_W = $bits(phase_pkg::angle_fields_t);

    phase_pkg::phase_t        acc;
    phase_pkg::phase_t        acc_next;
    phase_pkg::phase_t        offset_phase;
    phase_pkg::angle_fields_t fields;

    always_comb begin
        // Natural overflow of the phase word gives the modulo 2^N wrap
        acc_next = acc + freq_word;

        // The offset is added after the accumulator and never fed back into it
        // A new offset therefore shifts the output without disturbing the running phase
        offset_phase = acc_next + phase_offset;

        // Sector, index and fraction sit in the top bits of the offset phase
        fields = phase_pkg::angle_fields_t'(offset_phase[`NCO_PHASE_W-1 -: ANGLE_W]);
    end

    // Control state
    always_ff @(posedge clk) begin
        if (rst) begin
            acc         <= '0;
            angle.valid <= 1'b0;
        end else begin
            // One angle per enable strobe, valid for exactly one cycle
            angle.valid <= enable;

            // The accumulator holds while enable is low
            if (enable) begin
                acc <= acc_next;
            end
        end
    end

    // Angle payload
    // The fields are taken from the same new accumulator value that is stored above
    always_ff @(posedge clk) begin
        if (enable) begin
            angle.sector <= fields.sector;
            angle.index  <= fields.index;
            angle.frac   <= fields.frac;
        end
    end

endmodule

`default_nettype wire

// File: verilog/cosine_table.sv
/* Quarter-wave cosine table, filled at elaboration with a real-valued cosine.
   Returns the current and next sample with the quadrant sign applied, one cycle later */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

module cosine_table (
    input  logic    clk,
    input  logic    rst,
    angle_if.sink   angle,
    pair_if.source  pair
);

    // N, the number of table steps across one quadrant
    localparam int TABLE_N = 1 << `NCO_INDEX_W;

    // Addresses run from 0 to N inclusive, so they need one bit more than the index
    localparam int ADDR_W = `NCO_INDEX_W + 1;

    localparam real PI = 3.14159265358979323846;

    // Full-scale positive amplitude of one sample
    localparam real AMPLITUDE = real'((1 << (`NCO_SAMPLE_W - 1)) - 1);

    sample_pkg::sample_t rom [0:TABLE_N];

    // Entry i is cos(i * pi / (2N)) scaled to full scale and truncated toward zero
    // The last entry lands on pi/2 and comes out as zero
    initial begin
        for (int i = 0; i <= TABLE_N; i++) begin
            real step_angle;
            int  scaled;
            step_angle = real'(i) * PI / real'(2 * TABLE_N);
            scaled     = $rtoi($cos(step_angle) * AMPLITUDE);
            rom[i]     = sample_pkg::sample_t'(scaled);
        end
    end

    // Sectors 1 and 3 run the table backwards from N, sectors 0 and 2 forwards
    function automatic logic [ADDR_W-1:0] fold_addr(
        input logic [1:0]        sector,
        input logic [ADDR_W-1:0] k
    );
        logic [ADDR_W-1:0] addr;
        if (sector[0]) begin
            addr = ADDR_W'(TABLE_N) - k;
        end else begin
            addr = k;
        end
        return addr;
    endfunction

    logic [ADDR_W-1:0]          k_cur;
    logic [ADDR_W-1:0]          k_next;
    logic [ADDR_W-1:0]          addr_cur;
    logic [ADDR_W-1:0]          addr_next;
    logic                       negate;
    sample_pkg::sample_t        raw_cur;
    sample_pkg::sample_t        raw_next;
    sample_pkg::sample_pair_t   pair_d;
    sample_pkg::sample_pair_t   pair_q;
    logic [`NCO_FRAC_W-1:0]     frac_q;

    always_comb begin
        k_cur  = {1'b0, angle.index};
        // The next step stays in the current sector even when it reaches N
        // There it lands on T[N] in sectors 0 and 2 and on T[0] in sectors 1 and 3
        k_next = k_cur + 1'b1;

        addr_cur  = fold_addr(angle.sector, k_cur);
        addr_next = fold_addr(angle.sector, k_next);

        raw_cur  = rom[addr_cur];
        raw_next = rom[addr_next];

        // The cosine is negative in the middle two quadrants
        negate = angle.sector[0] ^ angle.sector[1];

        pair_d.cur  = negate ? -raw_cur  : raw_cur;
        pair_d.next = negate ? -raw_next : raw_next;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pair.valid <= 1'b0;
        end else begin
            pair.valid <= angle.valid;
        end
    end

    // Sample pair and fraction move on together with valid
    always_ff @(posedge clk) begin
        if (angle.valid) begin
            pair_q <= pair_d;
            frac_q <= angle.frac;
        end
    end

    assign pair.cur  = pair_q.cur;
    assign pair.next = pair_q.next;
    assign pair.frac = frac_q;

endmodule

`default_nettype wire

// File: verilog/sample_interpolator.sv
/* Linear interpolation between two signed samples. The step is floored by an arithmetic
   shift, and the sum is saturated to the sample range */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

module sample_interpolator (
    input  logic                clk,
    input  logic                rst,
    pair_if.sink                pair,
    output sample_pkg::sample_t cos_out,
    output logic                sample_valid
);

    // The difference of two samples needs one extra bit
    localparam int DIFF_W = `NCO_SAMPLE_W + 1;

    // Signed difference times the fraction with a zero sign bit added
    localparam int PROD_W = DIFF_W + `NCO_FRAC_W + 1;

    localparam int SAT_MAX = (1 << (`NCO_SAMPLE_W - 1)) - 1;
    localparam int SAT_MIN = -(1 << (`NCO_SAMPLE_W - 1));

    logic signed [DIFF_W-1:0] diff;
    logic signed [PROD_W-1:0] prod;
    logic signed [PROD_W-1:0] step;
    logic signed [PROD_W-1:0] sum;
    sample_pkg::sample_t      sat;

    always_comb begin
        diff = DIFF_W'(pair.next) - DIFF_W'(pair.cur);

        // The fraction is unsigned, so it gets a zero on top before the signed multiply
        prod = diff * $signed({1'b0, pair.frac});

        // Arithmetic shift rounds toward minus infinity, matching floor()
        step = prod >>> `NCO_FRAC_W;

        sum = step + PROD_W'(pair.cur);

        // Clip to the signed sample range
        if (sum > SAT_MAX) begin
            sat = sample_pkg::sample_t'(SAT_MAX);
        end else if (sum < SAT_MIN) begin
            sat = sample_pkg::sample_t'(SAT_MIN);
        end else begin
            sat = sum[`NCO_SAMPLE_W-1:0];
        end
    end

    // The output is defined as zero after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            cos_out      <= '0;
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= pair.valid;
            // Hold the last sample between strobes
            if (pair.valid) begin
                cos_out <= sat;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/nco_top.sv
/* NCO top level with plain ports. Each enable strobe gives one cos_out sample with
   sample_valid three clock edges later, and there is no back-pressure */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

module nco_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  phase_pkg::phase_t   freq_word,
    input  phase_pkg::phase_t   phase_offset,
    output sample_pkg::sample_t cos_out,
    output logic                sample_valid
);

    // Decoded angle between stage 1 and stage 2
    angle_if angle_link ();

    // Signed sample pair between stage 2 and stage 3
    pair_if pair_link ();

    // Stage 1 accumulates the phase, adds the offset and splits the angle
    phase_decoder decoder0 (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .freq_word    (freq_word),
        .phase_offset (phase_offset),
        .angle        (angle_link.source)
    );

    // Stage 2 looks up the folded table samples
    cosine_table table0 (
        .clk   (clk),
        .rst   (rst),
        .angle (angle_link.sink),
        .pair  (pair_link.source)
    );

    // Stage 3 interpolates and registers the output
    sample_interpolator interp0 (
        .clk          (clk),
        .rst          (rst),
        .pair         (pair_link.sink),
        .cos_out      (cos_out),
        .sample_valid (sample_valid)
    );

endmodule

`default_nettype wire

// File: bench/nco_checker.sv
/* Reference model and scoreboard for the NCO. A result must leave three edges after its
   enable, and a reset drops every result still in flight */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

module nco_checker (
    input  logic                clk,
    input  logic                rst,
    input  logic                enable,
    input  phase_pkg::phase_t   freq_word,
    input  phase_pkg::phase_t   phase_offset,
    input  sample_pkg::sample_t cos_out,
    input  logic                sample_valid,
    input  logic                test_end,
    input  int                  test_num,
    input  logic                all_done,
    output int                  error_count
);

    localparam int LATENCY    = 3;
    localparam int TABLE_N    = 1 << `NCO_INDEX_W;
    localparam int FULL_SCALE = (1 << (`NCO_SAMPLE_W - 1)) - 1;
    localparam int LOW_BITS   = `NCO_PHASE_W - 2 - `NCO_INDEX_W - `NCO_FRAC_W;

    int                ref_table [0:TABLE_N];
    int                exp_q [$];
    int                cycle_q [$];
    phase_pkg::phase_t ref_acc = '0;
    bit                zero_expected = 1'b0;
    int                cycle = 0;
    int                checked = 0;
    int                tests_done = 0;
    int                test_enables = 0;
    int                test_samples = 0;
    int                test_dropped = 0;
    int                test_err_base = 0;

    initial begin
        error_count = 0;
        // Quarter wave from 0 to pi/2 inclusive, truncated toward zero
        for (int i = 0; i <= TABLE_N; i++) begin
            ref_table[i] = $rtoi($cos(3.14159265358979 * i / (2.0 * TABLE_N)) * FULL_SCALE);
        end
    end

    // Odd sectors read the table backwards and the middle two sectors are negative
    function automatic int folded_sample(input int sector, input int k);
        case (sector)
            0:       return ref_table[k];
            1:       return -ref_table[TABLE_N - k];
            2:       return -ref_table[k];
            default: return ref_table[TABLE_N - k];
        endcase
    endfunction

    // Expected cosine for one phase word
    // The step to index k+1 stays in the same sector, even at k = N-1
    function automatic int expected_cosine(input phase_pkg::phase_t phase);
        int angle;
        int sector;
        int k;
        int frac;
        int cur;
        int diff;
        int value;
        angle  = int'(phase >> LOW_BITS);
        frac   = angle % (1 << `NCO_FRAC_W);
        k      = (angle >> `NCO_FRAC_W) % TABLE_N;
        sector = angle >> (`NCO_FRAC_W + `NCO_INDEX_W);
        cur    = folded_sample(sector, k);
        diff   = folded_sample(sector, k + 1) - cur;
        // Arithmetic shift floors the weighted step, negative ones too
        value  = cur + ((diff * frac) >>> `NCO_FRAC_W);
        if (value > FULL_SCALE) begin
            value = FULL_SCALE;
        end else if (value < -FULL_SCALE - 1) begin
            value = -FULL_SCALE - 1;
        end
        return value;
    endfunction

    // At the end of a test nothing may stay pending
    // Each enable that survived a reset has to have given exactly one sample
    task automatic report_test();
        if (exp_q.size() != 0) begin
            $display("Error: test %0d ended with %0d results never delivered",
                     test_num, exp_q.size());
            error_count++;
            exp_q.delete();
            cycle_q.delete();
        end
        if (test_samples != test_enables - test_dropped) begin
            $display("Error: test %0d saw %0d samples for %0d enables and %0d dropped",
                     test_num, test_samples, test_enables, test_dropped);
            error_count++;
        end
        $display("Test %0d done: %0d enables, %0d samples, %0d dropped by reset, %0d errors",
                 test_num, test_enables, test_samples, test_dropped,
                 error_count - test_err_base);
        tests_done++;
        test_enables  = 0;
        test_samples  = 0;
        test_dropped  = 0;
        test_err_base = error_count;
    endtask

    always @(posedge clk) begin
        int                  expected;
        int                  sent;
        sample_pkg::sample_t exp_sample;
        cycle++;
        // Until the first result after a reset the output reads as zero
        if (zero_expected) begin
            if (sample_valid === 1'b1) begin
                zero_expected = 1'b0;
            end else if (sample_valid !== 1'b0) begin
                $display("FAILED sample_valid: expected 0x0, got 0x%h", sample_valid);
                error_count++;
            end else if (cos_out !== '0) begin
                $display("FAILED cos_out: expected 0x0000, got 0x%h", cos_out);
                error_count++;
            end
        end
        if (sample_valid === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Error: sample_valid high at cycle %0d with no result pending", cycle);
                error_count++;
            end else begin
                expected   = exp_q.pop_front();
                sent       = cycle_q.pop_front();
                exp_sample = sample_pkg::sample_t'(expected);
                checked++;
                test_samples++;
                if (cos_out !== exp_sample) begin
                    $display("FAILED cos_out: expected 0x%h, got 0x%h", exp_sample, cos_out);
                    error_count++;
                end
                // An enable taken in at one edge is read back as a sample three edges later
                if (cycle - sent != LATENCY) begin
                    $display("Error: a result came %0d edges after its enable, not %0d",
                             cycle - sent, LATENCY);
                    error_count++;
                end
            end
        end
        // Reset wins over enable, and the model phase restarts from zero
        if (rst) begin
            test_dropped += exp_q.size();
            exp_q.delete();
            cycle_q.delete();
            ref_acc       = '0;
            zero_expected = 1'b1;
        end else if (enable) begin
            ref_acc = ref_acc + freq_word;
            exp_q.push_back(expected_cosine(ref_acc + phase_offset));
            cycle_q.push_back(cycle);
            test_enables++;
        end
        if (test_end) begin
            report_test();
        end
        if (all_done) begin
            $display("Summary: %0d tests, %0d samples checked, %0d errors",
                     tests_done, checked, error_count);
        end
    end

endmodule

`default_nettype wire

// File: bench/nco_tb.sv
/* NCO testbench top. Inputs change 1 ns after the rising edge and nco_checker does every
   comparison */
`timescale 1ns/10ps
`default_nettype none

`include "nco_params.svh"

module nco_tb;

    localparam int RESET_CYCLES = 8;
    localparam int QUIET_CYCLES = 8;
    localparam int DRAIN_CYCLES = 6;
    localparam int QUAD_HOLD    = 8;
    localparam int CONST_CYCLES = 1024;
    localparam int GATED_CYCLES = 512;
    localparam int SWEEP_BLOCK  = 64;
    localparam int SWEEP_BLOCKS = 16;
    localparam int MID_RUN      = 40;
    localparam int MID_RESET    = 3;
    localparam int LOW_BITS     = `NCO_PHASE_W - 2 - `NCO_INDEX_W - `NCO_FRAC_W;
    localparam int INDEX_SHIFT  = LOW_BITS + `NCO_FRAC_W;
    localparam int SECTOR_SHIFT = `NCO_PHASE_W - 2;

    // Each of the six tests ends with a drain and a one-cycle end marker
    localparam int TEST_CYCLES = RESET_CYCLES + QUIET_CYCLES + 4 * QUAD_HOLD + CONST_CYCLES
        + GATED_CYCLES + SWEEP_BLOCK * SWEEP_BLOCKS + 2 * MID_RUN + MID_RESET
        + 6 * (DRAIN_CYCLES + 1);
    localparam int CYCLE_LIMIT = 2 * TEST_CYCLES;

    logic                clk = 1'b0;
    logic                rst;
    logic                enable;
    phase_pkg::phase_t   freq_word;
    phase_pkg::phase_t   phase_offset;
    sample_pkg::sample_t cos_out;
    logic                sample_valid;
    logic                test_end;
    int                  test_num;
    logic                all_done;
    int                  error_count;
    int                  cycles = 0;
    phase_pkg::phase_t   stim_phase = '0;

    always #5 clk = ~clk;

    nco_top dut0 (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .freq_word    (freq_word),
        .phase_offset (phase_offset),
        .cos_out      (cos_out),
        .sample_valid (sample_valid)
    );

    nco_checker chk0 (
        .clk          (clk),
        .rst          (rst),
        .enable       (enable),
        .freq_word    (freq_word),
        .phase_offset (phase_offset),
        .cos_out      (cos_out),
        .sample_valid (sample_valid),
        .test_end     (test_end),
        .test_num     (test_num),
        .all_done     (all_done),
        .error_count  (error_count)
    );

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // The running phase is tracked only to aim the sweep offsets at chosen angles
    task automatic next_cycle();
        @(posedge clk);
        if (rst) begin
            stim_phase = '0;
        end else if (enable) begin
            stim_phase = stim_phase + freq_word;
        end
        #1;
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // Latency is fixed at three edges, so a short drain empties the pipeline
    task automatic end_test(input int num);
        enable = 1'b0;
        wait_cycles(DRAIN_CYCLES);
        test_num = num;
        test_end = 1'b1;
        next_cycle();
        test_end = 1'b0;
    endtask

    task automatic run_quadrant_points();
        freq_word = '0;
        enable    = 1'b1;
        for (int q = 0; q < 4; q++) begin
            phase_offset = phase_pkg::phase_t'(q) << SECTOR_SHIFT;
            wait_cycles(QUAD_HOLD);
        end
        end_test(2);
    endtask

    task automatic run_constant_freq();
        // About nine full periods over the run
        freq_word    = phase_pkg::phase_t'(32'h0002_3a5b);
        phase_offset = '0;
        enable       = 1'b1;
        wait_cycles(CONST_CYCLES);
        end_test(3);
    endtask

    task automatic run_gated_enable();
        freq_word    = phase_pkg::phase_t'($urandom);
        phase_offset = phase_pkg::phase_t'($urandom);
        for (int i = 0; i < GATED_CYCLES; i++) begin
            // Roughly one cycle in three is a gap, and gaps may run back to back
            enable = ($urandom % 3) != 0;
            next_cycle();
        end
        end_test(4);
    endtask

    task automatic run_random_sweep();
        phase_pkg::phase_t target;
        enable = 1'b1;
        for (int b = 0; b < SWEEP_BLOCKS; b++) begin
            if (b < 4) begin
                // Start at index N-2 of sector b and creep across index N-1 into the next
                target = (phase_pkg::phase_t'(b) << SECTOR_SHIFT)
                    | (phase_pkg::phase_t'((1 << `NCO_INDEX_W) - 2) << INDEX_SHIFT)
                    | (phase_pkg::phase_t'((1 << `NCO_FRAC_W) - 32) << LOW_BITS);
                freq_word    = phase_pkg::phase_t'(16) << LOW_BITS;
                phase_offset = target - stim_phase - freq_word;
            end else begin
                freq_word    = phase_pkg::phase_t'($urandom);
                phase_offset = phase_pkg::phase_t'($urandom);
            end
            wait_cycles(SWEEP_BLOCK);
        end
        end_test(5);
    endtask

    task automatic run_mid_reset();
        freq_word    = phase_pkg::phase_t'($urandom);
        phase_offset = '0;
        enable       = 1'b1;
        wait_cycles(MID_RUN);
        // Enable stays high through the reset, so the phase restarts from 0 right after
        rst = 1'b1;
        wait_cycles(MID_RESET);
        rst = 1'b0;
        wait_cycles(MID_RUN);
        end_test(6);
    endtask

    initial begin
        void'($urandom(32'h31c5_1553));
        rst          = 1'b1;
        enable       = 1'b1;
        freq_word    = phase_pkg::phase_t'($urandom);
        phase_offset = '0;
        test_end     = 1'b0;
        test_num     = 0;
        all_done     = 1'b0;
        // Enable held high during reset must not start the pipeline
        wait_cycles(RESET_CYCLES);
        rst    = 1'b0;
        enable = 1'b0;
        wait_cycles(QUIET_CYCLES);
        end_test(1);
        run_quadrant_points();
        run_constant_freq();
        run_gated_enable();
        run_random_sweep();
        run_mid_reset();
        all_done = 1'b1;
        next_cycle();
        all_done = 1'b0;
        if (error_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
+incdir+verilog
verilog/phase_pkg.sv
verilog/sample_pkg.sv
verilog/nco_links.sv
verilog/phase_decoder.sv
verilog/cosine_table.sv
verilog/sample_interpolator.sv
verilog/nco_top.sv
bench/nco_checker.sv
bench/nco_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile the NCO testbench with Verilator, run it and search the log for the pass message
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f all.f --top-module nco_tb -o nco_sim \
    && ./obj_dir/nco_sim | tee sim.log \
    && grep -qF '*** TEST PASSED ***' sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
